//--- rtl/ifetch_pkg.sv
package ifetch_pkg;

    localparam int addr_w         = 32;
    localparam int data_w         = 32;
    localparam int beats_per_line = 4;
    localparam int offset_w       = $clog2(beats_per_line);

    // byte lane bits below the word index.
    localparam int byte_w      = $clog2(data_w / 8);
    localparam int line_off_w  = offset_w + byte_w;

    localparam logic [7:0] burst_len  = 8'(beats_per_line - 1);
    localparam logic [2:0] burst_size = 3'b010; // four bytes per beat.
    localparam logic [1:0] burst_incr = 2'b01;

    function automatic logic [addr_w-1:0] line_base(
        input logic [addr_w-1:0] addr
    );
        logic [addr_w-1:0] base;
        base = {addr[addr_w-1:line_off_w], {line_off_w{1'b0}}};
        return base;
    endfunction

    function automatic logic [offset_w-1:0] word_index(
        input logic [addr_w-1:0] addr
    );
        logic [offset_w-1:0] idx;
        idx = addr[line_off_w-1:byte_w];
        return idx;
    endfunction

endpackage

//--- rtl/fetch_req_port.sv
`timescale 1ns/10ps

module fetch_req_port
    import ifetch_pkg::*;
(
    input  logic                axi4_master,
    input  logic                rst,
    input  logic                rd_en,
    input  logic [addr_w-1:0]   rd_addr,
    input  logic                cancel,
    input  logic                burst_done,
    output logic                rd_busy,
    output logic                line_req,
    output logic [addr_w-1:0]   line_addr,
    output logic [offset_w-1:0] word_sel,
    output logic                deliver
);

    logic accept;
    logic accepted_q;
    logic done_q;

    assign accept = rd_en && !rd_busy;

    always_ff @(posedge axi4_master) begin
        if (rst) begin
            rd_busy    <= 1'b0;
            accepted_q <= 1'b0;
            line_req   <= 1'b0;
            done_q     <= 1'b0;
            deliver    <= 1'b0;
        end else begin
            accepted_q <= accept;
            line_req   <= accepted_q; // one cycle after acceptance.
            done_q     <= burst_done; // covers the delivery cycle.

            if (accept) begin
                rd_busy <= 1'b1;
                deliver <= 1'b1;
            end else if (done_q) begin
                rd_busy <= 1'b0;
            end

            if (rd_busy && cancel) begin
                deliver <= 1'b0; // burst still drains on the bus.
            end
        end
    end

    always_ff @(posedge axi4_master) begin
        if (accept) begin
            line_addr <= line_base(rd_addr);
            word_sel  <= word_index(rd_addr);
        end
    end

    // a request while busy is dropped, so warn the requester side.
    no_req_while_busy: assert property (
        @(posedge axi4_master) disable iff (rst)
        rd_en |-> !rd_busy
    ) else $warning("rd_en ignored while a fetch is in flight");

endmodule

//--- rtl/axi_burst_reader.sv
`timescale 1ns/10ps

module axi_burst_reader
    import ifetch_pkg::*;
(
    input  logic              axi4_master,
    input  logic              rst,
    input  logic              line_req,
    input  logic [addr_w-1:0] line_addr,
    input  logic              arready,
    input  logic [data_w-1:0] rdata,
    input  logic              rvalid,
    input  logic              rlast,
    output logic [addr_w-1:0] araddr,
    output logic              arvalid,
    output logic [7:0]        arlen,
    output logic [2:0]        arsize,
    output logic [1:0]        arburst,
    output logic [3:0]        arid,
    output logic              rready,
    output logic              burst_done,
    output logic              beat_valid,
    output logic [data_w-1:0] beat_data,
    output logic              beat_last
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } state_t;

    state_t              state;
    logic [offset_w-1:0] beat_cnt;
    logic                beat_take;

    assign arlen   = burst_len;
    assign arsize  = burst_size;
    assign arburst = burst_incr;
    assign arid    = 4'd0; // single id, no reordering.

    assign arvalid   = (state == st_addr);
    assign rready    = (state == st_data);
    assign beat_take = rvalid && rready;

    always_ff @(posedge axi4_master) begin
        if (rst) begin
            state      <= st_idle;
            beat_cnt   <= '0;
            beat_valid <= 1'b0;
            burst_done <= 1'b0;
        end else begin
            beat_valid <= beat_take;
            burst_done <= beat_take && rlast;

            case (state)
                st_idle: begin
                    if (line_req) begin
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (arready) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (beat_take && rlast) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase

            if (beat_take) begin
                beat_cnt <= rlast ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge axi4_master) begin
        if (line_req && state == st_idle) begin
            araddr <= line_addr;
        end
        beat_data <= rdata;
        beat_last <= rlast;
    end

    ar_hold: assert property (
        @(posedge axi4_master) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    req_in_idle: assert property (
        @(posedge axi4_master) disable iff (rst)
        line_req |-> state == st_idle
    );

    last_on_fourth: assert property (
        @(posedge axi4_master) disable iff (rst)
        beat_take |-> rlast == (beat_cnt == offset_w'(beats_per_line - 1))
    );

endmodule

//--- rtl/line_assembler.sv
`timescale 1ns/10ps

module line_assembler
    import ifetch_pkg::*;
(
    input  logic                axi4_master,
    input  logic                rst,
    input  logic                beat_valid,
    input  logic [data_w-1:0]   beat_data,
    input  logic                beat_last,
    input  logic [offset_w-1:0] word_sel,
    input  logic                deliver,
    output logic                rd_valid,
    output logic [data_w-1:0]   rd_data
);

    logic [data_w-1:0]   line_q [beats_per_line];
    logic [offset_w-1:0] beat_cnt;

    always_ff @(posedge axi4_master) begin
        if (rst) begin
            rd_valid <= 1'b0;
            beat_cnt <= '0;
        end else begin
            // cancelled fetches fill the line but stay silent.
            rd_valid <= beat_valid && beat_last && deliver;
            if (beat_valid) begin
                beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge axi4_master) begin
        if (beat_valid) begin
            line_q[beat_cnt] <= beat_data;
        end
    end

    assign rd_data = line_q[word_sel]; // line complete once rd_valid is up.

    valid_one_cycle: assert property (
        @(posedge axi4_master) disable iff (rst)
        rd_valid |=> !rd_valid
    );

    // the reader's last beat must land in the top slot.
    last_in_top_slot: assert property (
        @(posedge axi4_master) disable iff (rst)
        beat_valid && beat_last |-> beat_cnt == offset_w'(beats_per_line - 1)
    );

endmodule

//--- rtl/ifetch_axi_top.sv
`timescale 1ns/10ps

module ifetch_axi_top
    import ifetch_pkg::*;
(
    input  logic              axi4_master,
    input  logic              rst,
    input  logic              rd_en,
    input  logic [addr_w-1:0] rd_addr,
    input  logic              cancel,
    output logic              rd_busy,
    output logic              rd_valid,
    output logic [data_w-1:0] rd_data,
    output logic [addr_w-1:0] araddr,
    output logic              arvalid,
    input  logic              arready,
    output logic [7:0]        arlen,
    output logic [2:0]        arsize,
    output logic [1:0]        arburst,
    output logic [3:0]        arid,
    input  logic [data_w-1:0] rdata,
    input  logic              rvalid,
    output logic              rready,
    input  logic              rlast
);

    logic                line_req;
    logic [addr_w-1:0]   line_addr;
    logic [offset_w-1:0] word_sel;
    logic                deliver;
    logic                burst_done;
    logic                beat_valid;
    logic [data_w-1:0]   beat_data;
    logic                beat_last;

    fetch_req_port u_port (
        .axi4_master (axi4_master),
        .rst         (rst),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .cancel      (cancel),
        .burst_done  (burst_done),
        .rd_busy     (rd_busy),
        .line_req    (line_req),
        .line_addr   (line_addr),
        .word_sel    (word_sel),
        .deliver     (deliver)
    );

    axi_burst_reader u_reader (
        .axi4_master (axi4_master),
        .rst         (rst),
        .line_req    (line_req),
        .line_addr   (line_addr),
        .arready     (arready),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rlast       (rlast),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .arid        (arid),
        .rready      (rready),
        .burst_done  (burst_done),
        .beat_valid  (beat_valid),
        .beat_data   (beat_data),
        .beat_last   (beat_last)
    );

    line_assembler u_assembler (
        .axi4_master (axi4_master),
        .rst         (rst),
        .beat_valid  (beat_valid),
        .beat_data   (beat_data),
        .beat_last   (beat_last),
        .word_sel    (word_sel),
        .deliver     (deliver),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

endmodule

//--- tb/axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model
    import ifetch_pkg::*;
#(
    parameter int mem_words = 256
) (
    input  logic              axi4_master,
    input  logic              rst,
    input  logic [addr_w-1:0] araddr,
    input  logic              arvalid,
    input  logic [7:0]        arlen,
    output logic              arready,
    output logic [data_w-1:0] rdata,
    output logic              rvalid,
    input  logic              rready,
    output logic              rlast,
    input  logic              ar_stall,
    input  logic              r_stall
);

    localparam int idx_w = $clog2(mem_words);

    logic [data_w-1:0] mem [mem_words];
    logic              busy;
    logic [7:0]        beat;
    logic [7:0]        len;
    logic [idx_w-1:0]  base;
    logic              ar_hs;
    logic              r_hs;
    logic              ar_stall_s;
    logic              r_stall_s;
    logic              rst_s;
    logic [addr_w-1:0] araddr_s;
    logic [7:0]        arlen_s;

    initial begin
        logic [15:0] wa;
        for (int i = 0; i < mem_words; i++) begin
            wa = 16'(i * 4);
            mem[i] = {~wa, wa} ^ 32'h5a5a_0000; // word value tracks its byte address.
        end
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        busy    = 1'b0;
        beat    = '0;
        len     = '0;
        base    = '0;
    end

    always @(posedge axi4_master) begin
        ar_hs      = arvalid && arready; // handshakes as seen at the edge.
        r_hs       = rvalid && rready;
        ar_stall_s = ar_stall;
        r_stall_s  = r_stall;
        rst_s      = rst;
        araddr_s   = araddr;
        arlen_s    = arlen;
        #1;
        if (rst_s) begin
            busy    = 1'b0;
            arready = 1'b0;
            rvalid  = 1'b0;
            rlast   = 1'b0;
        end else begin
            if (ar_hs) begin
                busy = 1'b1;
                beat = '0;
                len  = arlen_s;
                base = araddr_s[idx_w+1:2];
            end else if (r_hs) begin
                if (rlast) begin
                    busy = 1'b0;
                end else begin
                    beat = beat + 8'd1;
                end
            end
            arready = !busy && !ar_stall_s;
            if (!busy) begin
                rvalid = 1'b0;
            end else if (!(rvalid && !r_hs)) begin
                rvalid = !r_stall_s; // an offered beat is held until taken.
            end
            rdata = mem[base + idx_w'(beat)];
            rlast = busy && (beat == len);
        end
    end

endmodule

//--- tb/tb_ifetch_axi.sv
`timescale 1ns/10ps

module tb_ifetch_axi
    import ifetch_pkg::*;
();

    localparam logic [31:0] lfsr_seed = 32'h6608aad8;
    localparam int mem_words      = 256;
    localparam int random_fetches = 20;
    localparam int fetch_total    = 28;
    localparam int timeout_cycles = fetch_total * 24 * 4; // worst fetch length times margin.

    logic              axi4_master;
    logic              rst;
    logic              rd_en;
    logic [addr_w-1:0] rd_addr;
    logic              cancel;
    logic              rd_busy;
    logic              rd_valid;
    logic [data_w-1:0] rd_data;
    logic [addr_w-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [7:0]        arlen;
    logic [2:0]        arsize;
    logic [1:0]        arburst;
    logic [3:0]        arid;
    logic [data_w-1:0] rdata;
    logic              rvalid;
    logic              rready;
    logic              rlast;
    logic              ar_stall;
    logic              r_stall;

    logic [31:0] lfsr_state;
    logic [31:0] stall_bits;
    logic [31:0] rand_addr [random_fetches];
    logic [31:0] last_rd_data;
    logic [31:0] last_araddr;
    logic [7:0]  last_arlen;
    logic [2:0]  last_arsize;
    logic [1:0]  last_arburst;
    logic [3:0]  last_arid;
    int          valid_count;
    int          ar_count;
    int          cycle_count;
    int          errors;
    int          tests_passed;
    int          tests_failed;

    ifetch_axi_top DUT (.*);

    axi_mem_model #(.mem_words(mem_words)) mem_model (.*);

    always #50 axi4_master = ~axi4_master;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [15:0] wa;
        wa = {6'd0, addr[9:2], 2'b00};
        return {~wa, wa} ^ 32'h5a5a_0000;
    endfunction

    always @(posedge axi4_master) begin
        #1;
        stall_bits = take_bits(2);
        ar_stall = stall_bits[0];
        r_stall  = stall_bits[1];
    end

    // bus and fetch monitor.
    always @(posedge axi4_master) begin
        if (rd_valid) begin
            valid_count  = valid_count + 1;
            last_rd_data = rd_data;
        end
        if (arvalid && arready) begin
            ar_count     = ar_count + 1;
            last_araddr  = araddr;
            last_arlen   = arlen;
            last_arsize  = arsize;
            last_arburst = arburst;
            last_arid    = arid;
        end
    end

    always @(posedge axi4_master) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: the fetch tests did not finish within %0d cycles", timeout_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors = errors + 1;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            tests_passed = tests_passed + 1;
            $display("%s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    task automatic wait_idle();
        while (rd_busy) begin
            @(posedge axi4_master);
            #1;
        end
    endtask

    // entered 1 ns after an edge.
    task automatic issue_fetch(input logic [31:0] addr, output int pulses,
                               output logic [31:0] data);
        int start;
        start   = valid_count;
        rd_addr = addr;
        rd_en   = 1'b1;
        @(posedge axi4_master);
        #1;
        rd_en = 1'b0;
        wait_idle();
        pulses = valid_count - start;
        data   = last_rd_data;
    endtask

    task automatic check_reset_state();
        int err0;
        err0 = errors;
        check_value("reset", 32'd0, 32'({rd_busy, rd_valid, arvalid, rready}));
        report_test("reset", err0);
    endtask

    task automatic fetch_each_offset();
        int          err0;
        int          pulses;
        logic [31:0] addr;
        logic [31:0] data;
        err0 = errors;
        for (int off = 0; off < 4; off++) begin
            addr = 32'h0000_0140 + 32'(off * 4);
            issue_fetch(addr, pulses, data);
            check_value("offsets", 32'd1, 32'(pulses));
            check_value("offsets", expected_word(addr), data);
            check_value("offsets", addr & 32'hffff_fff0, last_araddr);
            check_value("offsets", 32'd3, 32'(last_arlen)); // four beats.
            check_value("offsets", 32'd2, 32'(last_arsize));
            check_value("offsets", 32'd1, 32'(last_arburst));
            check_value("offsets", 32'd0, 32'(last_arid));
        end
        report_test("offsets", err0);
    endtask

    task automatic fetch_random_lines();
        int          err0;
        int          pulses;
        logic [31:0] data;
        err0 = errors;
        for (int i = 0; i < random_fetches; i++) begin
            issue_fetch(rand_addr[i], pulses, data);
            check_value("random", 32'd1, 32'(pulses));
            check_value("random", expected_word(rand_addr[i]), data);
        end
        report_test("random", err0);
    endtask

    task automatic cancel_then_fetch();
        int          err0;
        int          start;
        int          pulses;
        logic [31:0] data;
        err0    = errors;
        start   = valid_count;
        rd_addr = 32'h0000_0208;
        rd_en   = 1'b1;
        @(posedge axi4_master);
        #1;
        rd_en  = 1'b0;
        cancel = 1'b1; // fetch is in flight here.
        @(posedge axi4_master);
        #1;
        cancel = 1'b0;
        wait_idle();
        check_value("cancel", 32'd0, 32'(valid_count - start));
        issue_fetch(32'h0000_03f4, pulses, data);
        check_value("cancel", 32'd1, 32'(pulses));
        check_value("cancel", expected_word(32'h0000_03f4), data);
        report_test("cancel", err0);
    endtask

    task automatic ignore_busy_request();
        int err0;
        int start;
        int ar0;
        err0    = errors;
        start   = valid_count;
        ar0     = ar_count;
        rd_addr = 32'h0000_0054;
        rd_en   = 1'b1;
        @(posedge axi4_master);
        #1;
        rd_en = 1'b0;
        @(posedge axi4_master);
        #1;
        rd_addr = 32'h0000_02a0;
        rd_en   = 1'b1;
        @(posedge axi4_master);
        #1;
        rd_en = 1'b0;
        wait_idle();
        check_value("busy_ignore", 32'd1, 32'(valid_count - start));
        check_value("busy_ignore", 32'd1, 32'(ar_count - ar0));
        check_value("busy_ignore", expected_word(32'h0000_0054), last_rd_data);
        report_test("busy_ignore", err0);
    endtask

    initial begin
        lfsr_state   = lfsr_seed;
        axi4_master  = 1'b0;
        rst          = 1'b1;
        rd_en        = 1'b0;
        rd_addr      = '0;
        cancel       = 1'b0;
        ar_stall     = 1'b0;
        r_stall      = 1'b0;
        valid_count  = 0;
        ar_count     = 0;
        cycle_count  = 0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        last_rd_data = '0;
        last_araddr  = '0;
        for (int i = 0; i < random_fetches; i++) begin
            rand_addr[i] = take_bits(10); // stays inside the model memory.
        end
        repeat (2) @(posedge axi4_master);
        #1;
        rst = 1'b0;
        check_reset_state();
        fetch_each_offset();
        fetch_random_lines();
        cancel_then_fetch();
        ignore_busy_request();
        $display("tests passed: %0d, tests with errors: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- ifetch_axi_top.f
rtl/ifetch_pkg.sv
rtl/fetch_req_port.sv
rtl/axi_burst_reader.sv
rtl/line_assembler.sv
rtl/ifetch_axi_top.sv
tb/axi_mem_model.sv
tb/tb_ifetch_axi.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f ifetch_axi_top.f \
        --top-module tb_ifetch_axi -o sim_ifetch; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_ifetch)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
